// ==== logic/secv_pkg.sv ====
// Shared types for the execute subsystem; assumes XLEN = ILEN = 32 and RV32I base encodings only
package secv_pkg;

    localparam int XLEN = 32;                   // Data width, fixed by the immediate layout
    localparam int ILEN = 32;                   // Instruction width

    // Major opcodes handled here
    typedef enum logic [6:0] {
        OPCODE_LUI   = 7'b0110111,
        OPCODE_AUIPC = 7'b0010111,
        OPCODE_OPIMM = 7'b0010011
    } opcode_t;

    // OP-IMM sub-operations
    typedef enum logic [2:0] {
        F3_ADDI = 3'b000,
        F3_SLLI = 3'b001,
        F3_SLTI = 3'b010,
        F3_XORI = 3'b100,
        F3_SRLI = 3'b101,
        F3_ORI  = 3'b110,
        F3_ANDI = 3'b111
    } funct3_t;

    // I-type view of one instruction word, MSB first
    typedef struct packed {
        logic [11:0] imm_hi;                    // imm[11:0], or U-imm bits 31:20
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_t;

    typedef logic [XLEN-1:0] imm_t;             // Decoded immediate

    // Function unit select
    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_MOV  = 2'd1,
        UNIT_ALU  = 2'd2
    } unit_t;

    // Controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,                         // Waiting for a strobe
        ST_EXEC = 2'd1,                         // Unit enabled, result latched
        ST_WB   = 2'd2                          // Register write, retire strobe
    } state_t;

    // One retired instruction, 70 bits
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
        logic            err;                   // Illegal instruction
    } ret_t;

    // Single point for width extension; identity while XLEN is 32
    function automatic logic [XLEN-1:0] sext32(input imm_t imm);
        return imm;
    endfunction

endpackage

// ==== logic/secv_decode.sv ====
// Combinational decoder; only LUI, AUIPC and the listed OP-IMM ops are legal, SRAI is rejected
`timescale 1ns/1ps

module secv_decode (
    input  secv_pkg::inst_t   inst_i,           // Registered instruction
    output secv_pkg::unit_t   unit_o,           // Selected function unit
    output secv_pkg::imm_t    imm_o,            // Decoded immediate
    output logic              err_o             // Illegal instruction
);
    import secv_pkg::*;

    logic [ILEN-1:0] raw;                       // Flat word for the U-type slice
    imm_t            imm_u;
    imm_t            imm_i;

    assign raw   = inst_i;
    assign imm_u = {raw[ILEN-1:12], 12'b0};     // Upper 20 bits, low 12 cleared
    assign imm_i = {{(XLEN-12){inst_i.imm_hi[11]}}, inst_i.imm_hi};

    always_comb begin
        unit_o = UNIT_NONE;
        imm_o  = '0;
        err_o  = 1'b0;
        case (opcode_t'(inst_i.opcode))
            OPCODE_LUI, OPCODE_AUIPC: begin
                unit_o = UNIT_MOV;
                imm_o  = imm_u;
            end
            OPCODE_OPIMM: begin
                imm_o = imm_i;
                case (funct3_t'(inst_i.funct3))
                    F3_ADDI, F3_SLTI, F3_XORI, F3_ORI, F3_ANDI: unit_o = UNIT_ALU;
                    F3_SLLI, F3_SRLI: begin
                        // Shift amount only, upper bits must be clear
                        if (inst_i.imm_hi[11:5] == 7'b0) unit_o = UNIT_ALU;
                        else err_o = 1'b1;
                    end
                    default: err_o = 1'b1;      // SLTIU not supported
                endcase
            end
            default: err_o = 1'b1;              // Unknown opcode
        endcase
    end

endmodule

// ==== logic/mov.sv ====
// Move unit for LUI and AUIPC; expects a U-type immediate and drives zeros while not enabled
`timescale 1ns/1ps

module mov (
    input  secv_pkg::inst_t          inst_i,    // Instruction
    input  logic                     ena_i,     // Unit enable
    input  logic [secv_pkg::XLEN-1:0] pc_i,     // Current pc
    input  secv_pkg::imm_t           imm_i,     // U-type immediate
    output logic [secv_pkg::XLEN-1:0] rd_o,     // Result for rd
    output logic                     rd_wb_o    // Write rd
);
    import secv_pkg::*;

    logic [XLEN-1:0] ext_imm;

    assign ext_imm = sext32(imm_i);

    always_comb begin
        rd_o    = '0;
        rd_wb_o = 1'b0;
        if (ena_i) begin
            if (opcode_t'(inst_i.opcode) == OPCODE_LUI) begin
                rd_o    = ext_imm;              // Immediate as is
                rd_wb_o = 1'b1;
            end else if (opcode_t'(inst_i.opcode) == OPCODE_AUIPC) begin
                rd_o    = pc_i + ext_imm;       // Pc relative
                rd_wb_o = 1'b1;
            end
        end
    end

endmodule

// ==== logic/secv_alu.sv ====
// OP-IMM unit; no SLTIU or SRAI, shift amount taken from the immediate's low 5 bits
`timescale 1ns/1ps

module secv_alu (
    input  secv_pkg::inst_t           inst_i,   // Instruction
    input  logic                      ena_i,    // Unit enable
    input  logic [secv_pkg::XLEN-1:0] rs1_i,    // Source operand
    input  secv_pkg::imm_t            imm_i,    // Sign-extended I-type immediate
    output logic [secv_pkg::XLEN-1:0] rd_o,     // Result for rd
    output logic                      rd_wb_o   // Write rd
);
    import secv_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    assign op_b  = sext32(imm_i);
    assign shamt = imm_i[4:0];

    always_comb begin
        rd_o    = '0;
        rd_wb_o = 1'b0;
        if (ena_i) begin
            rd_wb_o = 1'b1;
            case (funct3_t'(inst_i.funct3))
                F3_ADDI: rd_o = rs1_i + op_b;
                F3_SLTI: begin
                    // Signed compare, result is 0 or 1
                    rd_o = ($signed(rs1_i) < $signed(op_b)) ? XLEN'(1) : '0;
                end
                F3_XORI: rd_o = rs1_i ^ op_b;
                F3_ORI:  rd_o = rs1_i | op_b;
                F3_ANDI: rd_o = rs1_i & op_b;
                F3_SLLI: rd_o = rs1_i << shamt;
                F3_SRLI: rd_o = rs1_i >> shamt;     // Logical, zero fill
                default: begin
                    rd_o    = '0;                   // Filtered by the decoder
                    rd_wb_o = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== logic/secv_regfile.sv ====
// 32 x XLEN register file; combinational read, one write per cycle, x0 hardwired to zero
`timescale 1ns/1ps

module secv_regfile (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [4:0]                rs1_i,     // Read address
    output logic [secv_pkg::XLEN-1:0] rs1_o,     // Read data
    input  logic                      wr_en_i,   // Write strobe
    input  logic [4:0]                rd_i,      // Write address
    input  logic [secv_pkg::XLEN-1:0] rd_data_i  // Write data
);
    import secv_pkg::*;

    logic [XLEN-1:0] regs [1:31];               // No storage for x0

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= rd_data_i;            // Writes to x0 dropped
        end
    end

    // x0 reads zero
    assign rs1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];

endmodule

// ==== logic/secv_pc.sv ====
// Program counter; loads RESET_PC on reset and steps by 4 per retire, no jumps or branches
`timescale 1ns/1ps

module secv_pc #(
    parameter logic [secv_pkg::XLEN-1:0] RESET_PC = '0    // Address after reset
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      step_i,   // Advance by one instruction
    output logic [secv_pkg::XLEN-1:0] pc_o      // Current instruction address
);
    import secv_pkg::*;

    logic [XLEN-1:0] pc_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (step_i) begin
            pc_q <= pc_q + XLEN'(4);            // Fixed 32-bit instructions
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== logic/secv_ctrl.sv ====
// Accept/execute/write-back FSM; one instruction in flight, strobes while busy are dropped
`timescale 1ns/1ps

module secv_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      inst_vld_i,   // Host strobe
    input  secv_pkg::inst_t           inst_i,       // Host instruction
    output secv_pkg::inst_t           inst_o,       // Held instruction
    input  logic [secv_pkg::XLEN-1:0] res_i,        // Unit result
    input  logic                      res_wb_i,     // Unit wants rd written
    input  logic                      err_i,        // Decoder error
    input  logic [secv_pkg::XLEN-1:0] pc_i,         // Current pc
    output logic                      exec_o,       // Unit enable phase
    output logic                      wb_o,         // Write-back phase
    output logic                      wr_en_o,      // Register file write
    output logic                      ret_vld_o,    // Retire strobe
    output secv_pkg::ret_t            ret_o         // Retire record
);
    import secv_pkg::*;

    state_t state_q;
    state_t state_d;
    inst_t  inst_q;
    ret_t   ret_q;
    logic   wb_q;                               // Latched write-back flag

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (inst_vld_i) state_d = ST_EXEC;
            ST_EXEC: state_d = ST_WB;
            ST_WB:   state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            wb_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_EXEC) wb_q <= res_wb_i;
        end
    end

    // Payload only, qualified by the state
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && inst_vld_i) inst_q <= inst_i;     // Accept
        if (state_q == ST_EXEC) begin
            ret_q.pc   <= pc_i;
            ret_q.rd   <= inst_q.rd;
            ret_q.data <= res_i;
            ret_q.err  <= err_i;
        end
    end

    assign inst_o    = inst_q;
    assign exec_o    = (state_q == ST_EXEC);
    assign wb_o      = (state_q == ST_WB);
    assign wr_en_o   = wb_o && wb_q && !ret_q.err;
    assign ret_vld_o = wb_o;                    // One cycle per instruction
    assign ret_o     = ret_q;

endmodule

// ==== logic/secv_exec_top.sv ====
// Execute subsystem top; host must wait for ret_vld_o before the next strobe, no back-pressure
`timescale 1ns/1ps

module secv_exec_top #(
    parameter logic [secv_pkg::XLEN-1:0] RESET_PC = '0    // First instruction address
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            inst_vld_i,         // Instruction strobe
    input  secv_pkg::inst_t inst_i,             // Instruction word
    output logic            ret_vld_o,          // Retire strobe
    output secv_pkg::ret_t  ret_o               // Retire record
);
    import secv_pkg::*;

    inst_t           inst;                      // Held instruction
    unit_t           unit;
    imm_t            imm;
    logic            dec_err;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_data;
    logic            exec;
    logic            wb;
    logic            wr_en;
    logic [XLEN-1:0] mov_rd;
    logic            mov_wb;
    logic [XLEN-1:0] alu_rd;
    logic            alu_wb;
    logic [XLEN-1:0] res;
    logic            res_wb;

    // Disabled units drive zero, so an OR merges them
    assign res    = mov_rd | alu_rd;
    assign res_wb = mov_wb | alu_wb;

    secv_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .inst_vld_i (inst_vld_i),
        .inst_i     (inst_i),
        .inst_o     (inst),
        .res_i      (res),
        .res_wb_i   (res_wb),
        .err_i      (dec_err),
        .pc_i       (pc),
        .exec_o     (exec),
        .wb_o       (wb),
        .wr_en_o    (wr_en),
        .ret_vld_o  (ret_vld_o),
        .ret_o      (ret_o)
    );

    secv_decode u_decode (.inst_i(inst), .unit_o(unit), .imm_o(imm), .err_o(dec_err));

    mov u_mov (
        .inst_i  (inst),
        .ena_i   (exec && (unit == UNIT_MOV)),
        .pc_i    (pc),
        .imm_i   (imm),
        .rd_o    (mov_rd),
        .rd_wb_o (mov_wb)
    );

    secv_alu u_alu (
        .inst_i  (inst),
        .ena_i   (exec && (unit == UNIT_ALU)),
        .rs1_i   (rs1_data),
        .imm_i   (imm),
        .rd_o    (alu_rd),
        .rd_wb_o (alu_wb)
    );

    secv_regfile u_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rs1_i     (inst.rs1),
        .rs1_o     (rs1_data),
        .wr_en_i   (wr_en),
        .rd_i      (ret_o.rd),                  // Same as the held rd
        .rd_data_i (ret_o.data)
    );

    secv_pc #(.RESET_PC(RESET_PC)) u_pc (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .step_i  (wb),                          // One step per retire
        .pc_o    (pc)
    );

endmodule

// ==== bench/secv_exec_asserts.sv ====
// Controller checks bound to every secv_ctrl; a strobe while busy does not count as an accept
`timescale 1ns/1ps

module secv_exec_asserts (
    input logic           clk_i,
    input logic           rst_n_i,
    input logic           inst_vld_i,
    input logic           exec_o,
    input logic           wb_o,
    input logic           wr_en_o,
    input logic           ret_vld_o,
    input secv_pkg::ret_t ret_o
);
    logic accept;
    int   fail_count = 0;                        // Failed assertions so far

    assign accept = inst_vld_i && !exec_o && !wb_o;    // Strobe seen while idle

    // Retire strobe lasts one cycle
    ret_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ret_vld_o |=> !ret_vld_o)
        else begin
            $error("ret_vld_o high for two cycles in a row");
            fail_count++;
        end

    // Accepted strobe retires two edges later
    ret_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept |=> !ret_vld_o ##1 ret_vld_o)
        else begin
            $error("No retire two cycles after an accepted strobe");
            fail_count++;
        end

    // No retire without a matching accept
    ret_has_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ret_vld_o |-> $past(accept, 2))
        else begin
            $error("Retire without an accepted strobe two cycles before");
            fail_count++;
        end

    wr_no_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_en_o |-> !ret_o.err)
        else begin
            $error("Register write for an illegal instruction");
            fail_count++;
        end

endmodule

bind secv_ctrl secv_exec_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .inst_vld_i (inst_vld_i),
    .exec_o     (exec_o),
    .wb_o       (wb_o),
    .wr_en_o    (wr_en_o),
    .ret_vld_o  (ret_vld_o),
    .ret_o      (ret_o)
);

// ==== bench/secv_exec_tb.sv ====
// Directed testbench for secv_exec_top with RESET_PC 0x1000; stops at the first mismatch
`timescale 1ns/1ps

module secv_exec_tb;
    import secv_pkg::*;

    logic        clk_i;
    logic        rst_n_i;
    logic        inst_vld_i;
    inst_t       inst_i;
    logic        ret_vld_o;
    ret_t        ret_o;
    integer      seed;
    logic [31:0] model_regs [32];              // Expected register contents
    logic [31:0] model_pc;                     // Expected pc of the next retire

    secv_exec_top #(.RESET_PC(32'h0000_1000)) uut (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .inst_vld_i (inst_vld_i),
        .inst_i     (inst_i),
        .ret_vld_o  (ret_vld_o),
        .ret_o      (ret_o)
    );

    always #10 clk_i = ~clk_i;                 // 20 ns period

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Controller assertion failures end the run
    always @(uut.u_ctrl.u_asserts.fail_count) begin
        if (uut.u_ctrl.u_asserts.fail_count != 0) stop_run("Controller assertion failed");
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            stop_run("Value mismatch");
        end
    endtask

    function automatic inst_t enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPCODE_OPIMM};
    endfunction

    function automatic inst_t enc_u(input opcode_t op, input logic [4:0] rd,
                                    input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // Reference result from the RV32I rules
    function automatic void model_exec(input inst_t w, output logic [31:0] data,
                                       output logic err);
        logic [31:0] u_imm;
        logic [31:0] i_imm;
        logic [31:0] src;
        u_imm = {w.imm_hi, w.rs1, w.funct3, 12'h000};
        i_imm = {{20{w.imm_hi[11]}}, w.imm_hi};
        src   = model_regs[w.rs1];
        data  = '0;                            // Idle units give zero
        err   = 1'b0;
        if (w.opcode == OPCODE_LUI) data = u_imm;
        else if (w.opcode == OPCODE_AUIPC) data = model_pc + u_imm;
        else if (w.opcode == OPCODE_OPIMM) begin
            case (w.funct3)
                F3_ADDI: data = src + i_imm;
                F3_SLTI: data = ($signed(src) < $signed(i_imm)) ? 32'd1 : 32'd0;
                F3_XORI: data = src ^ i_imm;
                F3_ORI:  data = src | i_imm;
                F3_ANDI: data = src & i_imm;
                F3_SLLI, F3_SRLI: begin
                    if (w.imm_hi[11:5] != 7'b0) err = 1'b1;    // Upper shift bits set
                    else if (w.funct3 == F3_SLLI) data = src << w.imm_hi[4:0];
                    else data = src >> w.imm_hi[4:0];
                end
                default: err = 1'b1;           // SLTIU
            endcase
        end else err = 1'b1;
    endfunction

    // Waits for the retire, checks it, then steps the model
    task automatic finish_inst(input inst_t w);
        int          cycles;
        logic [31:0] exp_data;
        logic        exp_err;
        cycles = 0;
        while (!ret_vld_o) begin
            if (cycles == 10) stop_run("Timed out waiting for ret_vld_o");
            else begin
                @(posedge clk_i);
                #1;
                cycles++;
            end
        end
        model_exec(w, exp_data, exp_err);
        check_eq("ret_o.pc", model_pc, ret_o.pc);
        check_eq("ret_o.rd", w.rd, ret_o.rd);
        check_eq("ret_o.data", exp_data, ret_o.data);
        check_eq("ret_o.err", exp_err, ret_o.err);
        if (!exp_err && w.rd != 5'd0) model_regs[w.rd] = exp_data;
        model_pc = model_pc + 32'd4;
    endtask

    task automatic send_inst(input inst_t w);
        @(posedge clk_i);
        #1;
        inst_vld_i = 1'b1;
        inst_i     = w;
        @(posedge clk_i);
        #1;
        inst_vld_i = 1'b0;                     // Single-cycle strobe
        finish_inst(w);
    endtask

    task automatic test_pc_sequence();
        for (int i = 0; i < 3; i++) send_inst(enc_i(F3_ADDI, 5'd1, 5'd0, 12'(i)));
    endtask

    task automatic test_mov();
        logic [19:0] imm;
        for (int i = 0; i < 4; i++) begin
            imm = $random(seed);
            send_inst(enc_u(OPCODE_LUI, 5'(i + 2), imm));
            imm = $random(seed);
            send_inst(enc_u(OPCODE_AUIPC, 5'(i + 8), imm));
        end
    endtask

    task automatic test_opimm();
        logic [11:0] a;
        logic [11:0] b;
        for (int i = 0; i < 6; i++) begin
            a = $random(seed);
            b = $random(seed);
            send_inst(enc_i(F3_ADDI, 5'd5, 5'd0, a));         // Operand from x0
            send_inst(enc_i(F3_ADDI, 5'd6, 5'd5, b));
            send_inst(enc_i(F3_SLTI, 5'd7, 5'd5, b));
            send_inst(enc_i(F3_XORI, 5'd7, 5'd5, b));
            send_inst(enc_i(F3_ORI, 5'd7, 5'd5, b));
            send_inst(enc_i(F3_ANDI, 5'd7, 5'd5, b));
            send_inst(enc_i(F3_SLLI, 5'd7, 5'd5, {7'b0, b[4:0]}));
            send_inst(enc_i(F3_SRLI, 5'd7, 5'd6, {7'b0, b[9:5]}));
        end
        send_inst(enc_i(F3_ADDI, 5'd5, 5'd0, 12'hff0));       // x5 = -16
        send_inst(enc_i(F3_SLTI, 5'd7, 5'd5, 12'hffe));       // -16 < -2
        send_inst(enc_i(F3_SLTI, 5'd7, 5'd5, 12'h800));       // Not below -2048
    endtask

    task automatic test_x0();
        send_inst(enc_i(F3_ADDI, 5'd0, 5'd0, 12'h123));       // Retires with data
        send_inst(enc_i(F3_ADDI, 5'd12, 5'd0, 12'h000));
        check_eq("x0 read", 32'd0, ret_o.data);
    endtask

    task automatic test_illegal();
        send_inst(enc_i(F3_ADDI, 5'd9, 5'd0, 12'h5a5));
        send_inst({12'h000, 5'd1, 3'b000, 5'd9, 7'b0110011}); // Register-register OP
        send_inst(enc_i(3'b011, 5'd9, 5'd1, 12'h003));        // SLTIU
        send_inst(enc_i(F3_SRLI, 5'd9, 5'd1, 12'h402));       // SRAI form
        send_inst(enc_i(F3_ADDI, 5'd10, 5'd9, 12'h000));      // x9 unchanged
    endtask

    task automatic test_double_strobe();
        inst_t first;
        inst_t second;
        first  = enc_i(F3_ADDI, 5'd13, 5'd0, 12'h077);
        second = enc_i(F3_ADDI, 5'd14, 5'd0, 12'h0ee);
        @(posedge clk_i);
        #1;
        inst_vld_i = 1'b1;
        inst_i     = first;
        @(posedge clk_i);
        #1;
        inst_i = second;                       // Dropped while busy
        @(posedge clk_i);
        #1;
        inst_vld_i = 1'b0;
        finish_inst(first);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_i);
            #1;
            check_eq("ret_vld_o", 32'd0, ret_vld_o);
        end
        send_inst(enc_i(F3_ADDI, 5'd15, 5'd14, 12'h000));     // Pc stepped once, x14 zero
    endtask

    initial begin
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        inst_vld_i = 1'b0;
        inst_i     = '0;
        seed       = 32'hd274;
        model_pc   = 32'h0000_1000;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        test_pc_sequence();
        test_mov();
        test_opimm();
        test_x0();
        test_illegal();
        test_double_strobe();
        repeat (2) @(posedge clk_i);           // Let the last assertions settle
        #1;
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== compile.f ====
logic/secv_pkg.sv
logic/secv_decode.sv
logic/mov.sv
logic/secv_alu.sv
logic/secv_regfile.sv
logic/secv_pc.sv
logic/secv_ctrl.sv
logic/secv_exec_top.sv
bench/secv_exec_asserts.sv
bench/secv_exec_tb.sv
